/* Bender.yml */
package:
  name: wb_stage

sources:
  - files:
      - logic/wb_pkg.sv
      - logic/stage_latch.sv
      - logic/wb_commit_ctrl.sv
      - logic/wb_result_router.sv
      - logic/arch_reg_file.sv
      - logic/wb_stage.sv
  - target: simulation
    files:
      - tb/wb_stage_props.sv
      - tb/tb_wb_stage.sv

/* all.f */
logic/wb_pkg.sv
logic/stage_latch.sv
logic/wb_commit_ctrl.sv
logic/wb_result_router.sv
logic/arch_reg_file.sv
logic/wb_stage.sv
tb/wb_stage_props.sv
tb/tb_wb_stage.sv

/* logic/arch_reg_file.sv */
module arch_reg_file import wb_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  gpr_wr_t [NUM_SLOTS-1:0] gpr_wr,
    input  seg_wr_t [NUM_SLOTS-1:0] seg_wr,
    input  logic                    eflags_wr_en,
    input  logic [EFLAGS_W-1:0]     eflags_in,
    input  logic [REG_IDX_W-1:0]    gpr_rd_idx,
    input  logic [REG_IDX_W-1:0]    seg_rd_idx,
    output logic [XLEN-1:0]         gpr_rd_data,
    output logic [SEG_W-1:0]        seg_rd_data,
    output logic [EFLAGS_W-1:0]     eflags
);

    logic [XLEN-1:0]  gpr [NUM_GPR];
    logic [SEG_W-1:0] seg [NUM_SEG];

    // Later slots override earlier ones on the same register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_GPR; r++) begin
                gpr[r] <= '0;
            end
        end else begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                if (gpr_wr[s].en) begin
                    for (int b = 0; b < XLEN / 8; b++) begin
                        if (gpr_wr[s].byte_mask[b]) // Unmasked bytes keep old value
                            gpr[gpr_wr[s].idx][8*b +: 8] <= gpr_wr[s].data[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_SEG; r++) begin
                seg[r] <= '0;
            end
        end else begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                if (seg_wr[s].en && seg_wr[s].idx < NUM_SEG)
                    seg[seg_wr[s].idx] <= seg_wr[s].data;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            eflags <= '0;
        else if (eflags_wr_en)
            eflags <= eflags_in;
    end

    assign gpr_rd_data = gpr[gpr_rd_idx];

    always_comb begin
        if (seg_rd_idx < NUM_SEG)
            seg_rd_data = seg[seg_rd_idx];
        else
            seg_rd_data = '0; // No such segment register
    end

endmodule

/* logic/stage_latch.sv */
module stage_latch import wb_pkg::*; #(
    parameter type payload_t = ex_wb_t
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ld,
    input  logic     clr,
    input  payload_t d,
    output payload_t q,
    output logic     fresh
);

    // Clear beats load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q     <= '0;
            fresh <= 1'b0;
        end else if (clr) begin
            q     <= '0;
            fresh <= 1'b0;
        end else if (ld) begin
            q     <= d;
            fresh <= 1'b1;
        end else begin
            fresh <= 1'b0; // Held item, already seen downstream
        end
    end

endmodule

/* logic/wb_commit_ctrl.sv */
module wb_commit_ctrl import wb_pkg::*; (
    input  ex_wb_t    wb_item,
    input  logic      fresh,
    output logic      commit,
    output redirect_t redirect,
    output exc_t      exc
);

    logic live;
    logic dir_miss;
    logic tgt_miss;

    // Act on each latched item exactly once
    assign live   = fresh & wb_item.valid;
    assign commit = live & ~wb_item.ie;

    always_comb begin
        exc.valid   = live & wb_item.ie;
        exc.ie_type = wb_item.ie_type;
        exc.eip     = wb_item.eip;
    end

    assign dir_miss = wb_item.br_taken != wb_item.br_pred_taken;
    assign tgt_miss = wb_item.br_taken && (wb_item.br_fip != wb_item.br_pred_target);

    always_comb begin
        redirect.valid  = commit & wb_item.br_valid & (dir_miss | tgt_miss);
        // Resume at the resolved path
        redirect.target = wb_item.br_taken ? wb_item.br_fip : wb_item.br_fip_p1;
    end

endmodule

/* logic/wb_pkg.sv */
package wb_pkg;

    localparam int NUM_SLOTS = 4;
    localparam int NUM_GPR   = 8;
    localparam int NUM_SEG   = 6;

    localparam int REG_IDX_W = $clog2(NUM_GPR); // Also covers the segment file
    localparam int XLEN      = 32;
    localparam int SEG_W     = 16;
    localparam int EFLAGS_W  = 18;
    localparam int IE_TYPE_W = 4;

    // Result size codes, 2'd3 is handled as 32-bit
    localparam logic [1:0] SIZE_8  = 2'd0;
    localparam logic [1:0] SIZE_16 = 2'd1;
    localparam logic [1:0] SIZE_32 = 2'd2;

    typedef struct packed {
        logic        wb;
        logic        is_reg;
        logic        is_seg;
        logic        is_mem;
        logic [31:0] dest;    // Register index or memory address
        logic [63:0] value;
    } res_slot_t;

    typedef struct packed {
        logic                 valid;
        logic [XLEN-1:0]      eip;
        logic                 ie;      // Exception raised upstream
        logic [IE_TYPE_W-1:0] ie_type;
        logic [EFLAGS_W-1:0]  eflags;
        logic [1:0]           ressize;
        logic                 br_valid;
        logic                 br_taken;
        logic                 br_pred_taken;
        logic [XLEN-1:0]      br_pred_target;
        logic [XLEN-1:0]      br_fip;    // Taken target
        logic [XLEN-1:0]      br_fip_p1; // Fall-through address
        res_slot_t [NUM_SLOTS-1:0] slots;
    } ex_wb_t;

    typedef struct packed {
        logic                 en;
        logic [REG_IDX_W-1:0] idx;
        logic [XLEN-1:0]      data;
        logic [XLEN/8-1:0]    byte_mask;
    } gpr_wr_t;

    typedef struct packed {
        logic                 en;
        logic [REG_IDX_W-1:0] idx;
        logic [SEG_W-1:0]     data;
    } seg_wr_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
        logic [1:0]      size;
    } mem_wr_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic                 valid;
        logic [IE_TYPE_W-1:0] ie_type;
        logic [XLEN-1:0]      eip;
    } exc_t;

endpackage

/* logic/wb_result_router.sv */
module wb_result_router import wb_pkg::*; (
    input  ex_wb_t                    wb_item,
    input  logic                      commit,
    output gpr_wr_t [NUM_SLOTS-1:0]   gpr_wr,
    output seg_wr_t [NUM_SLOTS-1:0]   seg_wr,
    output mem_wr_t                   mem_wr
);

    logic [XLEN/8-1:0]    size_mask;
    logic [NUM_SLOTS-1:0] live;  // Slots written back by this item

    always_comb begin
        case (wb_item.ressize)
            SIZE_8:  size_mask = 4'b0001;
            SIZE_16: size_mask = 4'b0011;
            SIZE_32: size_mask = 4'b1111;
            default: size_mask = 4'b1111;
        endcase
    end

    always_comb begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            live[s] = commit & wb_item.slots[s].wb;
        end
    end

    // Register and segment writes, one per slot
    always_comb begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            gpr_wr[s].en        = live[s] & wb_item.slots[s].is_reg;
            gpr_wr[s].idx       = wb_item.slots[s].dest[REG_IDX_W-1:0];
            gpr_wr[s].data      = wb_item.slots[s].value[XLEN-1:0];
            gpr_wr[s].byte_mask = size_mask;

            seg_wr[s].en   = live[s] & wb_item.slots[s].is_seg;
            seg_wr[s].idx  = wb_item.slots[s].dest[REG_IDX_W-1:0];
            seg_wr[s].data = wb_item.slots[s].value[SEG_W-1:0];
        end
    end

    // Single store port, lowest memory slot wins
    always_comb begin
        mem_wr = '0;
        for (int s = NUM_SLOTS - 1; s >= 0; s--) begin
            if (live[s] && wb_item.slots[s].is_mem) begin
                mem_wr.valid = 1'b1;
                mem_wr.addr  = wb_item.slots[s].dest;
                mem_wr.data  = wb_item.slots[s].value[XLEN-1:0];
                mem_wr.size  = wb_item.ressize;
            end
        end
    end

endmodule

/* logic/wb_stage.sv */
module wb_stage import wb_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ld,
    input  logic                 clr,
    input  ex_wb_t               ex_in,
    input  logic [REG_IDX_W-1:0] gpr_rd_idx,
    input  logic [REG_IDX_W-1:0] seg_rd_idx,
    output logic [XLEN-1:0]      gpr_rd_data,
    output logic [SEG_W-1:0]     seg_rd_data,
    output logic [EFLAGS_W-1:0]  eflags,
    output mem_wr_t              mem_wr,
    output redirect_t            redirect,
    output exc_t                 exc
);

    ex_wb_t                  wb_item;
    logic                    fresh;
    logic                    commit;
    gpr_wr_t [NUM_SLOTS-1:0] gpr_wr;
    seg_wr_t [NUM_SLOTS-1:0] seg_wr;

    // E/WB boundary
    stage_latch #(
        .payload_t (ex_wb_t)
    ) i_latch (
        .clk   (clk),
        .rst_n (rst_n),
        .ld    (ld),
        .clr   (clr),
        .d     (ex_in),
        .q     (wb_item),
        .fresh (fresh)
    );

    wb_commit_ctrl i_commit (
        .wb_item  (wb_item),
        .fresh    (fresh),
        .commit   (commit),
        .redirect (redirect),
        .exc      (exc)
    );

    wb_result_router i_router (
        .wb_item (wb_item),
        .commit  (commit),
        .gpr_wr  (gpr_wr),
        .seg_wr  (seg_wr),
        .mem_wr  (mem_wr)
    );

    arch_reg_file i_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .gpr_wr       (gpr_wr),
        .seg_wr       (seg_wr),
        .eflags_wr_en (commit),          // Flags follow every committed item
        .eflags_in    (wb_item.eflags),
        .gpr_rd_idx   (gpr_rd_idx),
        .seg_rd_idx   (seg_rd_idx),
        .gpr_rd_data  (gpr_rd_data),
        .seg_rd_data  (seg_rd_data),
        .eflags       (eflags)
    );

endmodule

/* tb/tb_wb_stage.sv */
module tb_wb_stage import wb_pkg::*; ();

    localparam int PERIOD     = 40;
    localparam int RST_CYCLES = 5;
    localparam int N_DIRECTED = 17;
    localparam int N_RANDOM   = 60;
    localparam int N_ITEMS    = N_DIRECTED + N_RANDOM;
    localparam int MARGIN     = 100;  // Register sweeps after directed items

    // Predicted pulses together with the architectural state
    typedef struct packed {
        mem_wr_t                        mem_wr;
        redirect_t                      redirect;
        exc_t                           exc;
        logic [NUM_GPR-1:0][XLEN-1:0]   gpr;
        logic [NUM_SEG-1:0][SEG_W-1:0]  seg;
        logic [EFLAGS_W-1:0]            eflags;
    } expect_t;

    logic                 clk;
    logic                 rst_n;
    logic                 ld;
    logic                 clr;
    ex_wb_t               ex_in;
    logic [REG_IDX_W-1:0] gpr_rd_idx;
    logic [REG_IDX_W-1:0] seg_rd_idx;
    logic [XLEN-1:0]      gpr_rd_data;
    logic [SEG_W-1:0]     seg_rd_data;
    logic [EFLAGS_W-1:0]  eflags;
    mem_wr_t              mem_wr;
    redirect_t            redirect;
    exc_t                 exc;

    integer     seed   = 32'hdd58;
    int         errors = 0;
    int         checks = 0;
    logic [2:0] rd_cnt = '0;  // Walks both read ports every cycle

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    wb_stage i_wb_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .ld          (ld),
        .clr         (clr),
        .ex_in       (ex_in),
        .gpr_rd_idx  (gpr_rd_idx),
        .seg_rd_idx  (seg_rd_idx),
        .gpr_rd_data (gpr_rd_data),
        .seg_rd_data (seg_rd_data),
        .eflags      (eflags),
        .mem_wr      (mem_wr),
        .redirect    (redirect),
        .exc         (exc)
    );

    // Reference model for one loaded item
    function automatic expect_t predict(input ex_wb_t it, input expect_t prev);
        expect_t    nx;
        logic       commit;
        logic [3:0] mask;
        logic       mem_found;
        logic [2:0] idx;
        nx          = prev;
        nx.mem_wr   = '0;
        nx.redirect = '0;
        nx.exc      = '0;
        commit      = it.valid && !it.ie;
        mem_found   = 1'b0;
        if (it.valid && it.ie) begin
            nx.exc.valid   = 1'b1;
            nx.exc.ie_type = it.ie_type;
            nx.exc.eip     = it.eip;
        end
        if (it.ressize == SIZE_8)
            mask = 4'b0001;
        else if (it.ressize == SIZE_16)
            mask = 4'b0011;
        else
            mask = 4'b1111;
        if (commit) begin
            nx.eflags = it.eflags;
            for (int s = 0; s < NUM_SLOTS; s++) begin
                idx = it.slots[s].dest[2:0];
                if (it.slots[s].wb && it.slots[s].is_reg) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mask[b])
                            nx.gpr[idx][8*b +: 8] = it.slots[s].value[8*b +: 8];
                    end
                end
                if (it.slots[s].wb && it.slots[s].is_seg && idx < NUM_SEG)
                    nx.seg[idx] = it.slots[s].value[15:0];
                if (it.slots[s].wb && it.slots[s].is_mem && !mem_found) begin
                    mem_found      = 1'b1;
                    nx.mem_wr.valid = 1'b1;
                    nx.mem_wr.addr  = it.slots[s].dest;
                    nx.mem_wr.data  = it.slots[s].value[31:0];
                    nx.mem_wr.size  = it.ressize;
                end
            end
            if (it.br_valid && ((it.br_taken != it.br_pred_taken) ||
                    (it.br_taken && it.br_fip != it.br_pred_target))) begin
                nx.redirect.valid  = 1'b1;
                nx.redirect.target = it.br_taken ? it.br_fip : it.br_fip_p1;
            end
        end
        return nx;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                   input logic [63:0] got_v);
        errors++;
        $display("Fail at %0t: %s expected %h, got %h", $time, name, exp_v, got_v);
    endtask

    task automatic check_outputs(input expect_t pulses, input expect_t regs);
        logic [SEG_W-1:0] seg_exp;
        seg_exp = (seg_rd_idx < NUM_SEG) ? regs.seg[seg_rd_idx] : '0;
        checks++;
        if (mem_wr.valid !== pulses.mem_wr.valid)
            report_mismatch("mem_wr.valid", pulses.mem_wr.valid, mem_wr.valid);
        if (pulses.mem_wr.valid && mem_wr.addr !== pulses.mem_wr.addr)
            report_mismatch("mem_wr.addr", pulses.mem_wr.addr, mem_wr.addr);
        if (pulses.mem_wr.valid && mem_wr.data !== pulses.mem_wr.data)
            report_mismatch("mem_wr.data", pulses.mem_wr.data, mem_wr.data);
        if (pulses.mem_wr.valid && mem_wr.size !== pulses.mem_wr.size)
            report_mismatch("mem_wr.size", pulses.mem_wr.size, mem_wr.size);
        if (redirect.valid !== pulses.redirect.valid)
            report_mismatch("redirect.valid", pulses.redirect.valid, redirect.valid);
        if (pulses.redirect.valid && redirect.target !== pulses.redirect.target)
            report_mismatch("redirect.target", pulses.redirect.target, redirect.target);
        if (exc.valid !== pulses.exc.valid)
            report_mismatch("exc.valid", pulses.exc.valid, exc.valid);
        if (pulses.exc.valid && exc.ie_type !== pulses.exc.ie_type)
            report_mismatch("exc.ie_type", pulses.exc.ie_type, exc.ie_type);
        if (pulses.exc.valid && exc.eip !== pulses.exc.eip)
            report_mismatch("exc.eip", pulses.exc.eip, exc.eip);
        if (gpr_rd_data !== regs.gpr[gpr_rd_idx])
            report_mismatch("gpr_rd_data", regs.gpr[gpr_rd_idx], gpr_rd_data);
        if (seg_rd_data !== seg_exp)
            report_mismatch("seg_rd_data", seg_exp, seg_rd_data);
        if (eflags !== regs.eflags)
            report_mismatch("eflags", regs.eflags, eflags);
    endtask

    // Inputs are sampled at the edge, outputs in the middle of the next cycle
    initial begin : compare
        expect_t state;
        expect_t pend;
        expect_t pulses;
        logic    pend_vld;
        state    = '0;
        pend     = '0;
        pulses   = '0;
        pend_vld = 1'b0;
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                state    = '0;
                pulses   = '0;
                pend_vld = 1'b0;
            end else begin
                if (pend_vld)
                    state = pend;  // Register file written on this edge
                pulses          = state;
                pulses.mem_wr   = '0;
                pulses.redirect = '0;
                pulses.exc      = '0;
                pend_vld        = ld && !clr;
                if (pend_vld) begin
                    pend   = predict(ex_in, state);
                    pulses = pend;
                end
            end
            @(negedge clk);
            check_outputs(pulses, state);
        end
    end

    task automatic drive(input logic ld_v, input logic clr_v, input ex_wb_t it);
        @(posedge clk);
        #2;
        ld         = ld_v;
        clr        = clr_v;
        ex_in      = it;
        gpr_rd_idx = rd_cnt;
        seg_rd_idx = rd_cnt;
        rd_cnt     = rd_cnt + 1'b1;
    endtask

    // Last item stays on the bus with ld low
    task automatic idle(input int n);
        repeat (n) drive(1'b0, 1'b0, ex_in);
    endtask

    task automatic send(input ex_wb_t it);
        drive(1'b1, 1'b0, it);
        idle(8);
    endtask

    function automatic ex_wb_t base_item(input logic [31:0] eip, input logic [1:0] size);
        ex_wb_t it;
        it         = '0;
        it.valid   = 1'b1;
        it.eip     = eip;
        it.ressize = size;
        it.eflags  = eip[17:0] ^ 18'h2a5a5;
        return it;
    endfunction

    function automatic res_slot_t make_slot(input logic r, input logic sg, input logic m,
                                            input logic [31:0] dest, input logic [63:0] value);
        res_slot_t sl;
        sl.wb     = 1'b1;
        sl.is_reg = r;
        sl.is_seg = sg;
        sl.is_mem = m;
        sl.dest   = dest;
        sl.value  = value;
        return sl;
    endfunction

    function automatic ex_wb_t branch_item(input logic [31:0] eip, input logic taken,
                                           input logic pred, input logic [31:0] pred_tgt);
        ex_wb_t it;
        it                = base_item(eip, SIZE_32);
        it.br_valid       = 1'b1;
        it.br_taken       = taken;
        it.br_pred_taken  = pred;
        it.br_fip         = eip + 32'h40;
        it.br_fip_p1      = eip + 32'd2;
        it.br_pred_target = pred_tgt;
        return it;
    endfunction

    task automatic rand_item(output ex_wb_t it);
        it                = '0;
        it.valid          = ($random(seed) & 7) != 0;
        it.eip            = $random(seed);
        it.ie             = ($random(seed) & 7) == 0;
        it.ie_type        = $random(seed);
        it.eflags         = $random(seed);
        it.ressize        = $random(seed);
        it.br_valid       = $random(seed);
        it.br_taken       = $random(seed);
        it.br_pred_taken  = $random(seed);
        it.br_fip         = $random(seed);
        it.br_fip_p1      = it.eip + 32'd4;
        it.br_pred_target = ($random(seed) & 1) ? it.br_fip : $random(seed);
        for (int s = 0; s < NUM_SLOTS; s++) begin
            it.slots[s] = make_slot($random(seed), $random(seed), $random(seed),
                                    $random(seed), {$random(seed), $random(seed)});
            it.slots[s].wb = $random(seed);
        end
    endtask

    initial begin : stimulus
        ex_wb_t it;
        rst_n      = 1'b0;
        ld         = 1'b0;
        clr        = 1'b0;
        ex_in      = '0;
        gpr_rd_idx = '0;
        seg_rd_idx = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Register writes at full, byte and word size
        it = base_item(32'h0000_1000, SIZE_32);
        it.slots[0] = make_slot(1, 0, 0, 32'd1, 64'hdead_beef_1122_3344);
        it.slots[1] = make_slot(1, 0, 0, 32'd2, 64'h0000_0000_aabb_ccdd);
        it.slots[2] = make_slot(1, 0, 0, 32'd7, 64'h0000_0000_0f0f_0f0f);
        send(it);
        it = base_item(32'h0000_1004, SIZE_8);
        it.slots[0] = make_slot(1, 0, 0, 32'd1, 64'h0000_0000_5566_77ff);
        it.slots[3] = make_slot(1, 0, 0, 32'd2, 64'h0000_0000_1234_5678);
        send(it);
        it = base_item(32'h0000_1008, SIZE_16);
        it.slots[1] = make_slot(1, 0, 0, 32'd7, 64'h0000_0000_9999_1234);
        send(it);
        it = base_item(32'h0000_100c, SIZE_32);
        it.slots[0] = make_slot(1, 0, 0, 32'd4, 64'h1);
        it.slots[1] = make_slot(1, 0, 0, 32'd4, 64'h2);
        it.slots[2] = make_slot(1, 0, 0, 32'd4, 64'h3);
        it.slots[3] = make_slot(1, 0, 0, 32'd4, 64'h4);
        it.slots[3].wb = 1'b0;                 // Slot 2 should win
        send(it);

        // Segment file, indices 6 and 7 do not exist
        it = base_item(32'h0000_1014, SIZE_32);
        it.slots[0] = make_slot(0, 1, 0, 32'd0, 64'h0000_0000_dead_0010);
        it.slots[1] = make_slot(0, 1, 0, 32'd5, 64'h15);
        it.slots[2] = make_slot(0, 1, 0, 32'd6, 64'h16);
        it.slots[3] = make_slot(0, 1, 0, 32'd7, 64'h17);
        send(it);
        it = base_item(32'h0000_1018, SIZE_8);
        it.slots[0] = make_slot(0, 1, 0, 32'h0000_0101, 64'h0101);
        it.slots[1] = make_slot(0, 1, 0, 32'd2, 64'h0202);
        it.slots[2] = make_slot(0, 1, 0, 32'd3, 64'h0303);
        it.slots[3] = make_slot(0, 1, 0, 32'd4, 64'h0404);
        send(it);

        // Store port
        it = base_item(32'h0000_101c, SIZE_16);
        it.slots[0] = make_slot(0, 0, 1, 32'h0000_2000, 64'h1111);
        it.slots[0].wb = 1'b0;
        it.slots[1] = make_slot(1, 0, 0, 32'd3, 64'h0000_0000_cafe_f00d);
        it.slots[2] = make_slot(0, 0, 1, 32'h8000_2004, 64'h7777_8888_4444_5555);
        it.slots[3] = make_slot(0, 0, 1, 32'h8000_2008, 64'h6666);
        send(it);
        it = base_item(32'h0000_1020, SIZE_8);
        it.slots[3] = make_slot(1, 0, 1, 32'h1000_0005, 64'h0000_0000_0000_00a5);
        send(it);

        // Branch resolution
        send(branch_item(32'h0000_3000, 1, 1, 32'h0000_3040));  // Correct taken
        send(branch_item(32'h0000_3100, 0, 1, 32'h0000_3140));
        send(branch_item(32'h0000_3200, 1, 0, 32'h0000_0000));
        send(branch_item(32'h0000_3300, 1, 1, 32'h0000_3390));  // Wrong target
        send(branch_item(32'h0000_3400, 0, 0, 32'h0000_5555));

        // Exception suppresses every write
        it = branch_item(32'h0000_4000, 1, 0, 32'h0);
        it.ie       = 1'b1;
        it.ie_type  = 4'hd;
        it.slots[0] = make_slot(1, 1, 1, 32'd0, 64'hffff_ffff_ffff_ffff);
        send(it);
        it.ie    = 1'b0;
        it.valid = 1'b0;
        send(it);

        // Clear with load drops the item
        it.valid = 1'b1;
        drive(1'b1, 1'b1, it);
        idle(4);
        it = base_item(32'h0000_5000, SIZE_32);
        it.slots[0] = make_slot(1, 0, 0, 32'd6, 64'h0000_0000_6666_0006);
        drive(1'b1, 1'b0, it);
        drive(1'b0, 1'b1, it);
        idle(4);

        for (int n = 0; n < N_RANDOM; n++) begin
            rand_item(it);
            drive(1'b1, 1'b0, it);
            idle({$random(seed)} % 3);  // Gap of zero keeps ld high
        end
        idle(3);
        @(negedge clk);

        $display("Checked %0d cycles, found %0d errors and %0d assertion failures",
                 checks, errors, i_wb_stage.i_props.fails);
        if (errors == 0 && i_wb_stage.i_props.fails == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    initial begin : watchdog
        #((N_ITEMS * 4 + RST_CYCLES + MARGIN) * PERIOD);
        $display("Timeout: the stimulus did not finish in the expected number of cycles");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* tb/wb_stage_props.sv */
module wb_stage_props import wb_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      ld,
    input mem_wr_t   mem_wr,
    input redirect_t redirect,
    input exc_t      exc
);

    int fails = 0;  // Failed assertions so far

    // Nothing leaves the stage while reset is held
    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !(mem_wr.valid || redirect.valid || exc.valid))
        else begin
            fails++;
            $error("output pulse seen during reset");
        end

    mem_wr_single: assert property (@(posedge clk) disable iff (!rst_n)
        mem_wr.valid && !ld |=> !mem_wr.valid)
        else begin
            fails++;
            $error("mem_wr.valid lasted more than one cycle");
        end

    redirect_single: assert property (@(posedge clk) disable iff (!rst_n)
        redirect.valid && !ld |=> !redirect.valid)
        else begin
            fails++;
            $error("redirect.valid lasted more than one cycle");
        end

    exc_single: assert property (@(posedge clk) disable iff (!rst_n)
        exc.valid && !ld |=> !exc.valid)
        else begin
            fails++;
            $error("exc.valid lasted more than one cycle");
        end

    exc_no_store: assert property (@(posedge clk) disable iff (!rst_n)
        !(exc.valid && mem_wr.valid))
        else begin
            fails++;
            $error("exc.valid and mem_wr.valid high together");
        end

endmodule

bind wb_stage wb_stage_props i_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .ld       (ld),
    .mem_wr   (mem_wr),
    .redirect (redirect),
    .exc      (exc)
);
